/* hdl/prbs_macros.svh */
`ifndef PRBS_MACROS_SVH
`define PRBS_MACROS_SVH

// parallel lanes in the bank, one word bit each
`define PRBS_LANES 32

// LFSR state width, also the checker history depth
`define PRBS_WIDTH 32

// default tap mask, bit k set taps state bit k
// taps on bits 30 and 2, an even tap count
`define PRBS_EQN 32'h4000_0004

// saturating error counter width
`define PRBS_CNT_W 16

`endif

/* hdl/prbs_pkg.sv */
`include "prbs_macros.svh"

package prbs_pkg;

    // one pipeline word, valid tag plus one bit per lane
    typedef struct packed {
        logic                   valid; // word carries data this cycle
        logic [`PRBS_LANES-1:0] data;  // lane i drives bit i
    } prbs_word_t;

    // impairment controls for the tx path
    typedef struct packed {
        logic                           invert;   // complement every valid word
        logic                           inj_err;  // one cycle pulse, flip one lane bit
        logic [$clog2(`PRBS_LANES)-1:0] inj_lane; // lane hit by inj_err
    } prbs_impair_t;

    // checker result seen at the top level
    typedef struct packed {
        logic                   locked;    // all lane histories full
        logic                   err_flag;  // some lane mismatched last valid word
        logic [`PRBS_CNT_W-1:0] err_count; // total mismatches, sticks at max
    } chk_status_t;

    // per lane seeds, lane 0 first
    parameter logic [`PRBS_WIDTH-1:0] lane_seeds [`PRBS_LANES] = '{
        32'h39406d25, 32'h1fa44802, 32'h5bda4b69, 32'h25fdb240,
        32'h397bbecb, 32'h4dbfed92, 32'h2ccb4df6, 32'h126dff6d,
        32'h562c834d, 32'h3726ddbf, 32'h37db2092, 32'h4b6dbfff,
        32'h3a827964, 32'h1b4949b6, 32'h5924d249, 32'h2492db6d,
        32'h3c214412, 32'h4ed01b49, 32'h2fe99200, 32'h16f692db,
        32'h55afad92, 32'h36ff6db6, 32'h322dff6d, 32'h49b6db6d,
        32'h3832edff, 32'h1d9b0092, 32'h5f6dffff, 32'h2db64924,
        32'h2b0949b6, 32'h6d249249, 32'h6492db6d, 32'h92492493
    };

endpackage

/* hdl/prbs_lfsr.sv */
`include "prbs_macros.svh"

module prbs_lfsr #(
    parameter int                n_prbs = 32,        // state width
    parameter logic [n_prbs-1:0] eqn    = `PRBS_EQN  // tap mask
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cke,      // global clock enable
    input  logic              stall,    // hold state while high
    input  logic              load,     // reload state from init_val
    input  logic [n_prbs-1:0] init_val, // lane seed
    output logic              bit_out   // feedback of the last step
);

    logic [n_prbs-1:0] state_q;  // shift register with bit 0 newest
    logic              fb;       // next output bit
    logic              step;     // advance this cycle

    // parity of the tapped state bits
    assign fb   = ^(state_q & eqn);
    assign step = cke & ~stall;

    // state comes out of reset holding the seed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= init_val;
        end else if (load) begin
            state_q <= init_val;                     // restart from the seed
        end else if (step) begin
            state_q <= {state_q[n_prbs-2:0], fb};    // shift left and feed bit 0
        end
    end

    // output bit registered alongside the step
    always_ff @(posedge clk) begin
        if (!load && step) begin
            bit_out <= fb;  // same value that enters bit 0
        end
    end

endmodule

/* hdl/prbs_lane_bank.sv */
`include "prbs_macros.svh"

module prbs_lane_bank import prbs_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cke,      // step enable
    input  logic       stall,    // freeze all lanes
    input  logic       load,     // reseed all lanes
    output prbs_word_t gen_word  // one bit per lane plus valid
);

    logic [`PRBS_LANES-1:0] lane_bits;  // registered lane outputs
    logic                   valid_q;    // high after a stepping edge

    // one LFSR per lane, common taps, own seed
    for (genvar i = 0; i < `PRBS_LANES; i++) begin : g_lane
        prbs_lfsr #(
            .n_prbs (`PRBS_WIDTH),
            .eqn    (`PRBS_EQN)
        ) u_lfsr (
            .clk      (clk),
            .arst_n   (arst_n),
            .cke      (cke),
            .stall    (stall),
            .load     (load),
            .init_val (lane_seeds[i]),
            .bit_out  (lane_bits[i])
        );
    end

    // valid follows the same enable as the lane step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cke & ~stall & ~load;  // load cycle makes no word
        end
    end

    // pack the word for the next stage
    always_comb begin
        gen_word.valid = valid_q;
        gen_word.data  = lane_bits;
    end

endmodule

/* hdl/prbs_err_inject.sv */
`include "prbs_macros.svh"

module prbs_err_inject import prbs_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  prbs_word_t   gen_word,  // from the lane bank
    input  prbs_impair_t impair,    // invert level and inject pulse
    output prbs_word_t   tx_word    // impaired word, one cycle later
);

    logic [`PRBS_LANES-1:0] inj_mask;  // one hot on an inject pulse
    logic [`PRBS_LANES-1:0] flip_mask; // all bits to toggle
    logic                   valid_q;
    logic [`PRBS_LANES-1:0] data_q;

    always_comb begin
        inj_mask = '0;
        if (impair.inj_err) begin
            inj_mask[impair.inj_lane] = 1'b1;  // single lane hit
        end
        // inversion and injection stack, an injected bit on an
        // inverted word ends up uninverted
        flip_mask = {`PRBS_LANES{impair.invert}} ^ inj_mask;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= gen_word.valid;  // valid passes straight through
        end
    end

    always_ff @(posedge clk) begin
        if (gen_word.valid) begin
            data_q <= gen_word.data ^ flip_mask;  // impair valid words only
        end else begin
            data_q <= gen_word.data;
        end
    end

    always_comb begin
        tx_word.valid = valid_q;
        tx_word.data  = data_q;
    end

endmodule

/* hdl/prbs_lane_checker.sv */
`include "prbs_macros.svh"

module prbs_lane_checker #(
    parameter logic [`PRBS_WIDTH-1:0] eqn = `PRBS_EQN  // must match the generator
) (
    input  logic clk,
    input  logic arst_n,
    input  logic load,      // drop lock and refill history
    input  logic rx_valid,  // rx_bit is live
    input  logic rx_bit,    // received lane bit
    output logic locked,    // history full, predictions trusted
    output logic mismatch   // this bit differs from the prediction
);

    localparam int FILL_W = $clog2(`PRBS_WIDTH) + 1;  // counts 0 to width

    logic [`PRBS_WIDTH-1:0] hist_q;  // last received bits, bit 0 newest
    logic [FILL_W-1:0]      fill_q;  // bits taken since load
    logic                   pred;    // expected next bit

    assign locked = (fill_q == FILL_W'(`PRBS_WIDTH));
    assign pred   = ^(hist_q & eqn);  // same recurrence as the LFSR

    // only compare once the history is self-synchronised
    assign mismatch = rx_valid & locked & ~load & (rx_bit ^ pred);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist_q <= '0;
            fill_q <= '0;
        end else if (load) begin
            hist_q <= '0;
            fill_q <= '0;  // relock from scratch
        end else if (rx_valid) begin
            // the received bit goes in even when wrong, so an error
            // is seen again as it passes each tap
            hist_q <= {hist_q[`PRBS_WIDTH-2:0], rx_bit};
            if (!locked) begin
                fill_q <= fill_q + 1'b1;  // stops at full
            end
        end
    end

endmodule

/* hdl/prbs_checker_bank.sv */
`include "prbs_macros.svh"

module prbs_checker_bank import prbs_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load,     // restart all lane checkers
    input  logic        clear,    // zero the error count only
    input  prbs_word_t  tx_word,  // received word
    output chk_status_t status    // lock, flag and count
);

    logic [`PRBS_LANES-1:0] lane_lock;  // per lane lock
    logic [`PRBS_LANES-1:0] lane_mis;   // per lane mismatch this cycle
    logic [`PRBS_CNT_W:0]   n_mis;      // lanes in error, one spare bit
    logic [`PRBS_CNT_W:0]   cnt_sum;    // count plus new errors
    logic [`PRBS_CNT_W-1:0] cnt_next;   // saturated sum
    logic [`PRBS_CNT_W-1:0] cnt_q;
    logic                   flag_q;

    for (genvar i = 0; i < `PRBS_LANES; i++) begin : g_chk
        prbs_lane_checker #(
            .eqn (`PRBS_EQN)
        ) u_chk (
            .clk      (clk),
            .arst_n   (arst_n),
            .load     (load),
            .rx_valid (tx_word.valid),
            .rx_bit   (tx_word.data[i]),
            .locked   (lane_lock[i]),
            .mismatch (lane_mis[i])
        );
    end

    // population count of failing lanes
    always_comb begin
        n_mis = '0;
        for (int i = 0; i < `PRBS_LANES; i++) begin
            n_mis = n_mis + {{`PRBS_CNT_W{1'b0}}, lane_mis[i]};
        end
        cnt_sum  = {1'b0, cnt_q} + n_mis;
        // carry out means the count overflowed, hold at all ones
        cnt_next = cnt_sum[`PRBS_CNT_W] ? '1 : cnt_sum[`PRBS_CNT_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_q <= 1'b0;
            cnt_q  <= '0;
        end else if (load) begin
            flag_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            flag_q <= |lane_mis;     // any lane wrong
            if (clear) begin
                cnt_q <= '0;         // clear beats a same cycle error
            end else begin
                cnt_q <= cnt_next;
            end
        end
    end

    always_comb begin
        status.locked    = &lane_lock;  // every lane must be locked
        status.err_flag  = flag_q;
        status.err_count = cnt_q;
    end

endmodule

/* hdl/prbs_top.sv */
module prbs_top import prbs_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         cke,      // generator step enable
    input  logic         stall,    // throttle, makes valid gaps
    input  logic         load,     // reseed and drop lock
    input  logic         clear,    // zero err_count
    input  prbs_impair_t impair,   // invert and inject controls
    output prbs_word_t   tx_word,  // impaired word on the wire
    output chk_status_t  status    // checker result
);

    prbs_word_t gen_word;  // raw lane bank output

    // stage 1, 32 seeded lanes
    prbs_lane_bank u_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .cke      (cke),
        .stall    (stall),
        .load     (load),
        .gen_word (gen_word)
    );

    // stage 2, register plus impairments
    prbs_err_inject u_inject (
        .clk      (clk),
        .arst_n   (arst_n),
        .gen_word (gen_word),
        .impair   (impair),
        .tx_word  (tx_word)
    );

    // stage 3, self-synchronising checkers on the tx word
    prbs_checker_bank u_check (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load),
        .clear   (clear),
        .tx_word (tx_word),
        .status  (status)
    );

endmodule

/* verification/prbs_tb.sv */
`include "prbs_macros.svh"

module prbs_tb import prbs_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 8;
    localparam int drain_ticks = 3;            // gen, tx and status registers
    localparam int lock_words  = `PRBS_WIDTH;  // history depth before lock

    typedef enum logic [2:0] {
        op_load, op_run, op_stall, op_inject, op_invert, op_clear
    } op_t;

    typedef struct packed {
        op_t                    op;
        logic [15:0]            cycles;      // words stepped in the row
        logic [4:0]             lane;        // inject target
        logic [`PRBS_CNT_W-1:0] exp_count;   // err_count once drained
        logic [7:0]             exp_flags;   // cycles with err_flag high in the row
        logic                   exp_locked;  // locked once drained
    } row_t;

    // each inject costs 3 mismatches at the flipped bit and as it passes taps 2 and 30
    // an inverted run of 40 words breaks the recurrence because the tap count is even
    // and costs 40 mismatches per lane once 32 clean words have flushed the history
    localparam int n_rows = 16;
    localparam row_t rows [n_rows] = '{
        '{op_load,   16'd0,  5'd0,  16'd0,    8'd0,  1'b0},
        '{op_run,    16'd31, 5'd0,  16'd0,    8'd0,  1'b0},  // one word short of lock
        '{op_run,    16'd1,  5'd0,  16'd0,    8'd0,  1'b1},  // 32nd word locks
        '{op_run,    16'd40, 5'd0,  16'd0,    8'd0,  1'b1},
        '{op_stall,  16'd60, 5'd0,  16'd0,    8'd0,  1'b1},
        '{op_inject, 16'd40, 5'd5,  16'd3,    8'd3,  1'b1},
        '{op_inject, 16'd40, 5'd17, 16'd6,    8'd3,  1'b1},
        '{op_inject, 16'd40, 5'd31, 16'd9,    8'd3,  1'b1},
        '{op_invert, 16'd40, 5'd0,  16'd1289, 8'd40, 1'b1},  // 9 plus 40 x 32 lanes
        '{op_stall,  16'd50, 5'd0,  16'd1289, 8'd0,  1'b1},
        '{op_clear,  16'd0,  5'd0,  16'd0,    8'd0,  1'b1},
        '{op_inject, 16'd40, 5'd0,  16'd3,    8'd3,  1'b1},
        '{op_load,   16'd0,  5'd0,  16'd0,    8'd0,  1'b0},  // back to the seeds
        '{op_run,    16'd31, 5'd0,  16'd0,    8'd0,  1'b0},
        '{op_stall,  16'd10, 5'd0,  16'd0,    8'd0,  1'b1},
        '{op_inject, 16'd40, 5'd9,  16'd3,    8'd3,  1'b1}
    };

    logic         clk = 1'b0;
    logic         arst_n;
    logic         cke;
    logic         stall;
    logic         load;
    logic         clear;
    prbs_impair_t impair;
    prbs_word_t   tx_word;
    chk_status_t  status;

    logic [`PRBS_WIDTH-1:0] model_state [`PRBS_LANES];  // reference lanes
    logic [`PRBS_LANES-1:0] exp_words [$];               // words still in the pipe
    prbs_impair_t           pend_impair;                 // impairment for last step
    logic [31:0]            rng_state = 32'd45;
    int                     taken;                       // valid words since load
    int                     flags_seen;                  // err_flag cycles in this row

    prbs_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (cke),
        .stall   (stall),
        .load    (load),
        .clear   (clear),
        .impair  (impair),
        .tx_word (tx_word),
        .status  (status)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic reseed_model();
        for (int i = 0; i < `PRBS_LANES; i++) begin
            model_state[i] = lane_seeds[i];
        end
    endtask

    // one step of every reference lane with the tap parity shifted in at bit 0
    function automatic logic [`PRBS_LANES-1:0] model_word();
        logic [`PRBS_LANES-1:0] w;
        logic                   fb;
        for (int i = 0; i < `PRBS_LANES; i++) begin
            fb = ^(model_state[i] & `PRBS_EQN);
            model_state[i] = {model_state[i][`PRBS_WIDTH-2:0], fb};
            w[i] = fb;  // lane output is the feedback bit
        end
        return w;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int i = 0; i < n_rows; i++) begin
            total += int'(rows[i].cycles) + drain_ticks + 1;
            if (rows[i].op == op_invert) begin
                total += lock_words;  // recovery words
            end
        end
        return 2 * total + 100;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // outputs sampled at the falling edge half a cycle after they change
    task automatic observe();
        logic [`PRBS_LANES-1:0] exp_data;
        check_eq("status.locked", 32'(status.locked), 32'(taken >= lock_words));
        if (status.err_flag !== 1'b0) begin
            flags_seen++;  // one per flagged cycle
        end
        if (tx_word.valid) begin
            if (exp_words.size() == 0) begin
                abort_run("tx_word was valid while no word was expected");
            end else begin
                exp_data = exp_words.pop_front();
                check_eq("tx_word.data", 32'(tx_word.data), 32'(exp_data));
                taken++;  // checker takes it on the next rising edge
            end
        end
    endtask

    // one clock with inputs driven on the falling edge
    task automatic tick(input logic cke_v, input logic stall_v, input logic load_v,
                        input logic clear_v, input logic inv_req, input logic inj_req,
                        input logic [4:0] lane_req);
        logic [`PRBS_LANES-1:0] w;
        @(negedge clk);
        observe();
        impair      = pend_impair;  // meets the word stepped one cycle ago
        pend_impair = '0;
        cke         = cke_v;
        stall       = stall_v;
        load        = load_v;
        clear       = clear_v;
        if (load_v) begin
            reseed_model();
            taken = 0;
        end else if (cke_v && !stall_v) begin
            w = model_word();
            if (inv_req) begin
                w = ~w;
            end
            if (inj_req) begin
                w[lane_req] = ~w[lane_req];  // single lane flip
            end
            exp_words.push_back(w);
            pend_impair = '{invert: inv_req, inj_err: inj_req, inj_lane: lane_req};
        end
    endtask

    task automatic run_row(input int idx, input row_t r);
        flags_seen = 0;
        case (r.op)
            op_load: begin
                tick(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0);
            end
            op_clear: begin
                tick(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0);
            end
            op_run: begin
                repeat (int'(r.cycles)) tick(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
            end
            op_stall: begin
                for (int i = 0; i < int'(r.cycles); i++) begin
                    while ((xorshift32() % 4) == 0) begin
                        tick(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);  // gap
                    end
                    tick(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
                end
            end
            op_inject: begin
                for (int i = 0; i < int'(r.cycles); i++) begin
                    tick(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, (i == 0), r.lane);
                end
            end
            op_invert: begin
                repeat (int'(r.cycles)) tick(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 5'd0);
                repeat (lock_words) tick(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
            end
            default: begin
                abort_run("table row holds an unknown operation");
            end
        endcase
        // let the last word reach the checker
        repeat (drain_ticks) tick(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
        check_eq("status.err_count", 32'(status.err_count), 32'(r.exp_count));
        check_eq("status.err_flag cycles", 32'(flags_seen), 32'(r.exp_flags));
        check_eq("status.locked", 32'(status.locked), 32'(r.exp_locked));
        check_eq("expected words left", 32'(exp_words.size()), 32'd0);
        $display("row %0d done, err_count %0d", idx, status.err_count);
    endtask

    initial begin : watchdog
        int limit;
        limit = watchdog_cycles();
        #(limit * clk_period);
        abort_run("timeout, the table did not finish in the allowed time");
    end

    initial begin
        arst_n      = 1'b0;
        cke         = 1'b0;
        stall       = 1'b0;
        load        = 1'b0;
        clear       = 1'b0;
        impair      = '0;
        pend_impair = '0;
        flags_seen  = 0;
        taken       = 0;
        reseed_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_row(i, rows[i]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/prbs_pkg.sv
hdl/prbs_lfsr.sv
hdl/prbs_lane_bank.sv
hdl/prbs_err_inject.sv
hdl/prbs_lane_checker.sv
hdl/prbs_checker_bank.sv
hdl/prbs_top.sv
verification/prbs_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the PRBS project with Verilator and run the testbench
# the simulator exits non-zero when the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --timescale 1ns/100ps \
    -Wno-fatal \
    --top-module prbs_tb \
    -f sources.f \
    -o prbs_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/prbs_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0
